// ==== rtl/axi_mem_defs.svh ====
// AXI memory bridge sizes
`ifndef AXI_MEM_DEFS_SVH
`define AXI_MEM_DEFS_SVH
`default_nettype none

// Byte address width.
`define AXI_MEM_ADDR_W 16
// Data word width.
`define AXI_MEM_DATA_W 32
// One strobe bit per data byte.
`define AXI_MEM_STRB_W (`AXI_MEM_DATA_W / 8)
// Transaction id width.
`define AXI_MEM_ID_W 4
// Burst length field, beats minus one.
`define AXI_MEM_LEN_W 8
// Outstanding memory requests and buffer depth.
`define AXI_MEM_BUF_DEPTH 4

`default_nettype wire
`endif

// ==== rtl/axi_mem_pkg.sv ====
// AXI memory bridge types
`include "axi_mem_defs.svh"
`default_nettype none

package axi_mem_pkg;

  // Channel payload types.
  typedef logic [`AXI_MEM_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_MEM_DATA_W-1:0] data_t;
  typedef logic [`AXI_MEM_STRB_W-1:0] strb_t;
  typedef logic [`AXI_MEM_ID_W-1:0]   id_t;
  typedef logic [`AXI_MEM_LEN_W-1:0]  len_t;

  // Per-beat bookkeeping, kept until the memory answers.
  typedef struct packed {
    id_t  id;
    logic last;
    logic write;
  } beat_meta_t;

  // One memory response.
  typedef struct packed {
    data_t data;
    logic  err;
  } mem_rsp_t;

  // AXI response codes in use.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

endpackage

`default_nettype wire

// ==== rtl/axi_to_mem_top.sv ====
// AXI to memory bridge top
`timescale 1ns/1ps
`include "axi_mem_defs.svh"
`default_nettype none

module axi_to_mem_top import axi_mem_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_i,
  // AR channel.
  input  wire logic  ar_valid_i,
  output logic       ar_ready_o,
  input  wire addr_t ar_addr_i,
  input  wire id_t   ar_id_i,
  input  wire len_t  ar_len_i,
  // AW channel.
  input  wire logic  aw_valid_i,
  output logic       aw_ready_o,
  input  wire addr_t aw_addr_i,
  input  wire id_t   aw_id_i,
  input  wire len_t  aw_len_i,
  // W channel.
  input  wire logic  w_valid_i,
  output logic       w_ready_o,
  input  wire data_t w_data_i,
  input  wire strb_t w_strb_i,
  input  wire logic  w_last_i,
  // R channel.
  output logic       r_valid_o,
  input  wire logic  r_ready_i,
  output data_t      r_data_o,
  output id_t        r_id_o,
  output resp_e      r_resp_o,
  output logic       r_last_o,
  // B channel.
  output logic       b_valid_o,
  input  wire logic  b_ready_i,
  output id_t        b_id_o,
  output resp_e      b_resp_o,
  // Memory port.
  output logic       mem_req_o,
  input  wire logic  mem_gnt_i,
  output addr_t      mem_addr_o,
  output logic       mem_we_o,
  output data_t      mem_wdata_o,
  output strb_t      mem_strb_o,
  input  wire logic  mem_rvalid_i,
  input  wire data_t mem_rdata_i,
  input  wire logic  mem_err_i
);

  // Tracker offers.
  logic       rd_valid, rd_last, rd_ongoing, rd_grant;
  logic       wr_valid, wr_last, wr_ongoing, wr_grant;
  addr_t      rd_addr, wr_addr;
  id_t        rd_id, wr_id;
  // Arbiter outputs.
  beat_meta_t meta_push;
  logic       meta_push_valid, meta_push_ready;
  addr_t      req_addr;
  logic       req_we, req_valid, req_ready;
  // Buffered metadata and responses.
  beat_meta_t meta_pop;
  logic       meta_pop_valid, meta_pop_ready;
  mem_rsp_t   rsp;
  logic       rsp_valid, rsp_ready;

  burst_tracker #(
    .NeedsData ( 1'b0 )
  ) u_rd_burst (
    .clk_i          ( clk_i      ),
    .rst_i          ( rst_i      ),
    .ax_valid_i     ( ar_valid_i ),
    .ax_ready_o     ( ar_ready_o ),
    .ax_addr_i      ( ar_addr_i  ),
    .ax_id_i        ( ar_id_i    ),
    .ax_len_i       ( ar_len_i   ),
    .data_valid_i   ( 1'b1       ),
    .beat_valid_o   ( rd_valid   ),
    .beat_addr_o    ( rd_addr    ),
    .beat_id_o      ( rd_id      ),
    .beat_last_o    ( rd_last    ),
    .beat_ongoing_o ( rd_ongoing ),
    .beat_grant_i   ( rd_grant   )
  );

  // Write beats are only offered while W data is present.
  burst_tracker #(
    .NeedsData ( 1'b1 )
  ) u_wr_burst (
    .clk_i          ( clk_i      ),
    .rst_i          ( rst_i      ),
    .ax_valid_i     ( aw_valid_i ),
    .ax_ready_o     ( aw_ready_o ),
    .ax_addr_i      ( aw_addr_i  ),
    .ax_id_i        ( aw_id_i    ),
    .ax_len_i       ( aw_len_i   ),
    .data_valid_i   ( w_valid_i  ),
    .beat_valid_o   ( wr_valid   ),
    .beat_addr_o    ( wr_addr    ),
    .beat_id_o      ( wr_id      ),
    .beat_last_o    ( wr_last    ),
    .beat_ongoing_o ( wr_ongoing ),
    .beat_grant_i   ( wr_grant   )
  );

  rw_arbiter u_arbiter (
    .clk_i        ( clk_i           ),
    .rst_i        ( rst_i           ),
    .rd_valid_i   ( rd_valid        ),
    .rd_addr_i    ( rd_addr         ),
    .rd_id_i      ( rd_id           ),
    .rd_last_i    ( rd_last         ),
    .rd_ongoing_i ( rd_ongoing      ),
    .rd_grant_o   ( rd_grant        ),
    .wr_valid_i   ( wr_valid        ),
    .wr_addr_i    ( wr_addr         ),
    .wr_id_i      ( wr_id           ),
    .wr_last_i    ( wr_last         ),
    .wr_ongoing_i ( wr_ongoing      ),
    .wr_grant_o   ( wr_grant        ),
    .w_ready_o    ( w_ready_o       ),
    .meta_o       ( meta_push       ),
    .meta_valid_o ( meta_push_valid ),
    .meta_ready_i ( meta_push_ready ),
    .req_addr_o   ( req_addr        ),
    .req_we_o     ( req_we          ),
    .req_valid_o  ( req_valid       ),
    .req_ready_i  ( req_ready       )
  );

  stream_fifo #(
    .T     ( beat_meta_t        ),
    .Depth ( `AXI_MEM_BUF_DEPTH )
  ) u_meta_fifo (
    .clk_i        ( clk_i           ),
    .rst_i        ( rst_i           ),
    .push_valid_i ( meta_push_valid ),
    .push_ready_o ( meta_push_ready ),
    .push_data_i  ( meta_push       ),
    .pop_valid_o  ( meta_pop_valid  ),
    .pop_ready_i  ( meta_pop_ready  ),
    .pop_data_o   ( meta_pop        )
  );

  // W data and strobe ride along with the granted write beat.
  mem_req_port u_mem_port (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .req_valid_i  ( req_valid    ),
    .req_ready_o  ( req_ready    ),
    .req_addr_i   ( req_addr     ),
    .req_we_i     ( req_we       ),
    .req_wdata_i  ( w_data_i     ),
    .req_strb_i   ( w_strb_i     ),
    .mem_req_o    ( mem_req_o    ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_addr_o   ( mem_addr_o   ),
    .mem_we_o     ( mem_we_o     ),
    .mem_wdata_o  ( mem_wdata_o  ),
    .mem_strb_o   ( mem_strb_o   ),
    .mem_rvalid_i ( mem_rvalid_i ),
    .mem_rdata_i  ( mem_rdata_i  ),
    .mem_err_i    ( mem_err_i    ),
    .rsp_o        ( rsp          ),
    .rsp_valid_o  ( rsp_valid    ),
    .rsp_ready_i  ( rsp_ready    )
  );

  resp_builder u_resp (
    .clk_i        ( clk_i          ),
    .rst_i        ( rst_i          ),
    .meta_i       ( meta_pop       ),
    .meta_valid_i ( meta_pop_valid ),
    .meta_ready_o ( meta_pop_ready ),
    .rsp_i        ( rsp            ),
    .rsp_valid_i  ( rsp_valid      ),
    .rsp_ready_o  ( rsp_ready      ),
    .r_valid_o    ( r_valid_o      ),
    .r_ready_i    ( r_ready_i      ),
    .r_data_o     ( r_data_o       ),
    .r_id_o       ( r_id_o         ),
    .r_resp_o     ( r_resp_o       ),
    .r_last_o     ( r_last_o       ),
    .b_valid_o    ( b_valid_o      ),
    .b_ready_i    ( b_ready_i      ),
    .b_id_o       ( b_id_o         ),
    .b_resp_o     ( b_resp_o       )
  );

  // The master's W last must agree with the beat count from AW len.
  a_w_last_match: assert property (@(posedge clk_i) disable iff (rst_i)
    w_valid_i && w_ready_o |-> (w_last_i == wr_last))
    else $error("W last does not match the AW burst length.");

endmodule

`default_nettype wire

// ==== rtl/burst_tracker.sv ====
// Burst beat generator
`timescale 1ns/1ps
`include "axi_mem_defs.svh"
`default_nettype none

module burst_tracker import axi_mem_pkg::*; #(
  // Set for the write side, where each beat also needs W data.
  parameter bit NeedsData = 1'b0
) (
  input  wire logic  clk_i,
  input  wire logic  rst_i,
  input  wire logic  ax_valid_i,
  output logic       ax_ready_o,
  input  wire addr_t ax_addr_i,
  input  wire id_t   ax_id_i,
  input  wire len_t  ax_len_i,
  input  wire logic  data_valid_i,
  output logic       beat_valid_o,
  output addr_t      beat_addr_o,
  output id_t        beat_id_o,
  output logic       beat_last_o,
  output logic       beat_ongoing_o,
  input  wire logic  beat_grant_i
);

  // Every beat is full width, so the address steps by the bus byte count.
  localparam int unsigned BeatBytes = `AXI_MEM_STRB_W;

  logic  busy_q;
  len_t  cnt_q;
  addr_t addr_q;
  id_t   id_q;
  logic  data_ok;

  // The read side never waits for data.
  assign data_ok = NeedsData ? data_valid_i : 1'b1;

  // First beat comes straight from the address channel.
  // Later beats come from the saved burst state.
  always_comb begin
    if (busy_q) begin
      beat_valid_o = data_ok;
      beat_addr_o  = addr_q;
      beat_id_o    = id_q;
      beat_last_o  = (cnt_q == '0);
    end else begin
      beat_valid_o = ax_valid_i & data_ok;
      beat_addr_o  = ax_addr_i;
      beat_id_o    = ax_id_i;
      beat_last_o  = (ax_len_i == '0);
    end
  end

  // Address channel is taken with the first beat's grant.
  assign ax_ready_o     = ~busy_q & beat_grant_i;
  assign beat_ongoing_o = busy_q;

  // Burst state.
  // cnt_q counts the beats left after the one on offer.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (beat_grant_i) begin
      busy_q <= ~beat_last_o;
      cnt_q  <= busy_q ? cnt_q - len_t'(1) : ax_len_i - len_t'(1);
    end
  end

  // Next beat address and the burst id.
  always_ff @(posedge clk_i) begin
    if (beat_grant_i) begin
      addr_q <= beat_addr_o + addr_t'(BeatBytes);
      if (!busy_q) begin
        id_q <= ax_id_i;
      end
    end
  end

  // The master must hold the request until it is taken.
  a_ax_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    ax_valid_i && !ax_ready_o |=> ax_valid_i && $stable({ax_addr_i, ax_id_i, ax_len_i}))
    else $error("Address channel changed while stalled.");

endmodule

`default_nettype wire

// ==== rtl/mem_req_port.sv ====
// Memory request port
`timescale 1ns/1ps
`include "axi_mem_defs.svh"
`default_nettype none

module mem_req_port import axi_mem_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_i,
  // Beat request from the arbiter.
  input  wire logic  req_valid_i,
  output logic       req_ready_o,
  input  wire addr_t req_addr_i,
  input  wire logic  req_we_i,
  input  wire data_t req_wdata_i,
  input  wire strb_t req_strb_i,
  // Memory side.
  output logic       mem_req_o,
  input  wire logic  mem_gnt_i,
  output addr_t      mem_addr_o,
  output logic       mem_we_o,
  output data_t      mem_wdata_o,
  output strb_t      mem_strb_o,
  input  wire logic  mem_rvalid_i,
  input  wire data_t mem_rdata_i,
  input  wire logic  mem_err_i,
  // Buffered responses.
  output mem_rsp_t   rsp_o,
  output logic       rsp_valid_o,
  input  wire logic  rsp_ready_i
);

  localparam int unsigned Depth = `AXI_MEM_BUF_DEPTH;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  logic [CntW-1:0] cnt_q;
  logic            room;
  logic            req_fire;
  logic            rsp_pop;
  logic            rsp_push_ready;
  mem_rsp_t        rsp_in;

  // Requests in flight plus responses not yet taken.
  // Keeping this at or below Depth means the FIFO always has space.
  assign room     = (cnt_q < CntW'(Depth));
  assign req_fire = req_valid_i & req_ready_o;
  assign rsp_pop  = rsp_valid_o & rsp_ready_i;

  // Requests pass straight to memory.
  assign mem_req_o   = req_valid_i & room;
  assign req_ready_o = room & mem_gnt_i;
  assign mem_addr_o  = req_addr_i;
  assign mem_we_o    = req_we_i;
  assign mem_wdata_o = req_wdata_i;
  assign mem_strb_o  = req_strb_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (req_fire && !rsp_pop) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (rsp_pop && !req_fire) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign rsp_in.data = mem_rdata_i;
  assign rsp_in.err  = mem_err_i;

  // Every memory answer is pushed, reads and writes alike.
  stream_fifo #(
    .T     ( mem_rsp_t ),
    .Depth ( Depth     )
  ) u_rsp_fifo (
    .clk_i        ( clk_i          ),
    .rst_i        ( rst_i          ),
    .push_valid_i ( mem_rvalid_i   ),
    .push_ready_o ( rsp_push_ready ),
    .push_data_i  ( rsp_in         ),
    .pop_valid_o  ( rsp_valid_o    ),
    .pop_ready_i  ( rsp_ready_i    ),
    .pop_data_o   ( rsp_o          )
  );

  // Memory must not answer requests that were never made.
  a_no_stray_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_rvalid_i |-> (cnt_q != '0) && rsp_push_ready)
    else $error("Memory response without an outstanding request.");

endmodule

`default_nettype wire

// ==== rtl/resp_builder.sv ====
// AXI R and B response builder
`timescale 1ns/1ps
`default_nettype none

module resp_builder import axi_mem_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_i,
  // Metadata FIFO output.
  input  wire beat_meta_t meta_i,
  input  wire logic       meta_valid_i,
  output logic            meta_ready_o,
  // Response FIFO output.
  input  wire mem_rsp_t   rsp_i,
  input  wire logic       rsp_valid_i,
  output logic            rsp_ready_o,
  // AXI R channel.
  output logic            r_valid_o,
  input  wire logic       r_ready_i,
  output data_t           r_data_o,
  output id_t             r_id_o,
  output resp_e           r_resp_o,
  output logic            r_last_o,
  // AXI B channel.
  output logic            b_valid_o,
  input  wire logic       b_ready_i,
  output id_t             b_id_o,
  output resp_e           b_resp_o
);

  logic both_valid;
  logic target_ready;
  logic fire;
  logic err_acc_q;

  assign both_valid = meta_valid_i & rsp_valid_i;

  // Reads wait for R, last writes wait for B, other writes drain at once.
  always_comb begin
    if (!meta_i.write) begin
      target_ready = r_ready_i;
    end else if (meta_i.last) begin
      target_ready = b_ready_i;
    end else begin
      target_ready = 1'b1;
    end
  end

  // Both FIFOs pop together.
  assign fire         = both_valid & target_ready;
  assign meta_ready_o = rsp_valid_i & target_ready;
  assign rsp_ready_o  = meta_valid_i & target_ready;

  // Read beats.
  assign r_valid_o = both_valid & ~meta_i.write;
  assign r_data_o  = rsp_i.data;
  assign r_id_o    = meta_i.id;
  assign r_last_o  = meta_i.last;
  assign r_resp_o  = rsp_i.err ? RESP_SLVERR : RESP_OKAY;

  // One B per burst, carrying any error seen in it.
  assign b_valid_o = both_valid & meta_i.write & meta_i.last;
  assign b_id_o    = meta_i.id;
  assign b_resp_o  = (err_acc_q | rsp_i.err) ? RESP_SLVERR : RESP_OKAY;

  // Error accumulator for the write burst in progress.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_acc_q <= 1'b0;
    end else if (fire && meta_i.write) begin
      err_acc_q <= meta_i.last ? 1'b0 : (err_acc_q | rsp_i.err);
    end
  end

  // R must hold while the master stalls it.
  a_r_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable({r_data_o, r_id_o, r_resp_o, r_last_o}))
    else $error("R changed while stalled.");

endmodule

`default_nettype wire

// ==== rtl/rw_arbiter.sv ====
// Read/write beat arbiter
`timescale 1ns/1ps
`default_nettype none

module rw_arbiter import axi_mem_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_i,
  // Read beat offer.
  input  wire logic  rd_valid_i,
  input  wire addr_t rd_addr_i,
  input  wire id_t   rd_id_i,
  input  wire logic  rd_last_i,
  input  wire logic  rd_ongoing_i,
  output logic       rd_grant_o,
  // Write beat offer.
  input  wire logic  wr_valid_i,
  input  wire addr_t wr_addr_i,
  input  wire id_t   wr_id_i,
  input  wire logic  wr_last_i,
  input  wire logic  wr_ongoing_i,
  output logic       wr_grant_o,
  output logic       w_ready_o,
  // Metadata FIFO push.
  output beat_meta_t meta_o,
  output logic       meta_valid_o,
  input  wire logic  meta_ready_i,
  // Memory request.
  output addr_t      req_addr_o,
  output logic       req_we_o,
  output logic       req_valid_o,
  input  wire logic  req_ready_i
);

  // Side encoding is 1 for write and 0 for read.
  logic sel;
  logic sel_q;
  logic lock_q;
  logic rr_q;
  logic sel_valid;
  logic grant;

  // Side selection.
  always_comb begin
    if (lock_q) begin
      // A stalled choice stays until granted.
      sel = sel_q;
    end else if (rd_valid_i ^ wr_valid_i) begin
      sel = wr_valid_i;
    end else if (wr_ongoing_i) begin
      // Finish running bursts before starting new ones.
      sel = 1'b1;
    end else if (rd_ongoing_i) begin
      sel = 1'b0;
    end else begin
      sel = rr_q;
    end
  end

  assign sel_valid = sel ? wr_valid_i : rd_valid_i;

  // Grant only when both consumers take the beat.
  assign grant = sel_valid & meta_ready_i & req_ready_i;

  assign rd_grant_o = grant & ~sel;
  assign wr_grant_o = grant & sel;
  assign w_ready_o  = grant & sel;

  // Each consumer sees valid qualified by the other's ready.
  assign meta_valid_o = sel_valid & req_ready_i;
  assign req_valid_o  = sel_valid & meta_ready_i;

  assign meta_o.id    = sel ? wr_id_i : rd_id_i;
  assign meta_o.last  = sel ? wr_last_i : rd_last_i;
  assign meta_o.write = sel;

  assign req_addr_o = sel ? wr_addr_i : rd_addr_i;
  assign req_we_o   = sel;

  // Lock and round-robin state.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q <= 1'b0;
      sel_q  <= 1'b0;
      rr_q   <= 1'b0;
    end else begin
      sel_q <= sel;
      if (grant) begin
        lock_q <= 1'b0;
        // The other side wins the next tie.
        rr_q   <= ~sel;
      end else if (sel_valid) begin
        lock_q <= 1'b1;
      end
    end
  end

  // A stalled beat stays offered with the same address and metadata until granted.
  a_stall_held: assert property (@(posedge clk_i) disable iff (rst_i)
    sel_valid && !grant |=> sel_valid && $stable({req_addr_o, meta_o}))
    else $error("Stalled beat withdrawn or changed before grant.");

endmodule

`default_nettype wire

// ==== rtl/stream_fifo.sv ====
// Valid/ready FIFO
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter type         T     = logic,
  parameter int unsigned Depth = 4
) (
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic push_valid_i,
  output logic      push_ready_o,
  input  wire T     push_data_i,
  output logic      pop_valid_o,
  input  wire logic pop_ready_i,
  output T          pop_data_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  T                mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW:0]   count_q;
  logic            push;
  logic            pop;

  assign push_ready_o = (count_q != (PtrW+1)'(Depth));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  // Pointers wrap at Depth, which need not be a power of two.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage.
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    count_q <= (PtrW+1)'(Depth))
    else $error("FIFO count above depth.");

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+rtl
rtl/axi_mem_pkg.sv
rtl/stream_fifo.sv
rtl/burst_tracker.sv
rtl/rw_arbiter.sv
rtl/mem_req_port.sv
rtl/resp_builder.sv
rtl/axi_to_mem_top.sv
verif/mem_model.sv
verif/tb_axi_to_mem.sv

// ==== verif/mem_model.sv ====
// Behavioral memory model
`timescale 1ns/1ps
`include "axi_mem_defs.svh"
`default_nettype none

module mem_model import axi_mem_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_i,
  input  wire logic  stall_i,
  input  wire logic  mem_req_i,
  output logic       mem_gnt_o,
  input  wire addr_t mem_addr_i,
  input  wire logic  mem_we_i,
  input  wire data_t mem_wdata_i,
  input  wire strb_t mem_strb_i,
  output logic       mem_rvalid_o,
  output data_t      mem_rdata_o,
  output logic       mem_err_o
);

  localparam int unsigned Words = 2 ** (`AXI_MEM_ADDR_W - 2);
  // Accesses from here up answer with an error.
  localparam addr_t ErrBase = 16'hF000;

  data_t                       mem [Words];
  logic [`AXI_MEM_ADDR_W-3:0]  idx;
  logic                        accept;
  logic [1:0]                  vld_q;
  data_t                       rd0_q;
  data_t                       rd1_q;
  logic                        err0_q;
  logic                        err1_q;

  // Fill pattern keyed on the word index.
  initial begin
    for (int i = 0; i < Words; i++) begin
      mem[i] = {16'(i) ^ 16'hC3A5, 16'(i)};
    end
  end

  assign mem_gnt_o = ~stall_i;
  assign accept    = mem_req_i & mem_gnt_o;
  assign idx       = mem_addr_i[`AXI_MEM_ADDR_W-1:2];

  // Two-stage answer pipeline.
  always @(posedge clk_i) begin
    if (rst_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[0], accept};
    end
    rd1_q  <= rd0_q;
    err1_q <= err0_q;
    if (accept) begin
      rd0_q  <= mem[idx];
      err0_q <= (mem_addr_i >= ErrBase);
      // Writes into the error region are dropped.
      if (mem_we_i && mem_addr_i < ErrBase) begin
        for (int b = 0; b < `AXI_MEM_STRB_W; b++) begin
          if (mem_strb_i[b]) begin
            mem[idx][8*b +: 8] <= mem_wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  assign mem_rvalid_o = vld_q[1];
  assign mem_rdata_o  = rd1_q;
  assign mem_err_o    = err1_q;

endmodule

`default_nettype wire

// ==== verif/tb_axi_to_mem.sv ====
// AXI to memory bridge testbench
`timescale 1ns/1ps
`include "axi_mem_defs.svh"
`default_nettype none

module tb_axi_to_mem import axi_mem_pkg::*; ();

  localparam int NumTxn  = 16;
  localparam int Timeout = 2000;
  localparam addr_t ErrBase = 16'hF000;

  // One table row per AXI transaction.
  typedef struct packed {
    logic [3:0] test;
    logic       write;
    addr_t      addr;
    id_t        id;
    len_t       len;
    data_t      seed;
    strb_t      strb;
    logic [1:0] resp;
  } txn_t;

  // Expected R beat.
  typedef struct packed {
    id_t        id;
    data_t      data;
    logic [1:0] resp;
    logic       last;
    logic       check_data;
  } rbeat_t;

  // Expected B response.
  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } bexp_t;

  logic  clk_i, rst_i;
  logic  ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o;
  addr_t ar_addr_i, aw_addr_i;
  id_t   ar_id_i, aw_id_i, r_id_o, b_id_o;
  len_t  ar_len_i, aw_len_i;
  logic  w_valid_i, w_ready_o, w_last_i;
  data_t w_data_i, r_data_o;
  strb_t w_strb_i;
  logic  r_valid_o, r_ready_i, r_last_o, b_valid_o, b_ready_i;
  resp_e r_resp_o, b_resp_o;
  logic  mem_req_o, mem_gnt_i, mem_we_o, mem_rvalid_i, mem_err_i, mem_stall;
  addr_t mem_addr_o;
  data_t mem_wdata_o, mem_rdata_i;
  strb_t mem_strb_o;

  txn_t   tbl [NumTxn];
  rbeat_t rexp_q [$];
  bexp_t  bexp_q [$];
  data_t  shadow [int unsigned];
  int     err_cnt = 0;
  int     chk_cnt = 0;
  int     tests_run = 0;
  int     tests_failed = 0;

  axi_to_mem_top dut (.*);

  mem_model u_mem (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .stall_i      ( mem_stall    ),
    .mem_req_i    ( mem_req_o    ),
    .mem_gnt_o    ( mem_gnt_i    ),
    .mem_addr_i   ( mem_addr_o   ),
    .mem_we_i     ( mem_we_o     ),
    .mem_wdata_i  ( mem_wdata_o  ),
    .mem_strb_i   ( mem_strb_o   ),
    .mem_rvalid_o ( mem_rvalid_i ),
    .mem_rdata_o  ( mem_rdata_i  ),
    .mem_err_o    ( mem_err_i    )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Byte-wise merge of a write into the shadow word.
  function automatic data_t apply_strobe(input data_t old, input data_t wdata, input strb_t strb);
    data_t res;
    res = old;
    for (int k = 0; k < `AXI_MEM_STRB_W; k++) begin
      if (strb[k]) begin
        res[8*k +: 8] = wdata[8*k +: 8];
      end
    end
    return res;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic finish_run();
    $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    err_cnt++;
    finish_run();
  endtask

  // Grant stalls and R/B back-pressure, one draw per cycle.
  initial begin : stall_gen
    logic [31:0] rng;
    rng = 32'h1374e8f3;
    mem_stall = 1'b0;
    r_ready_i = 1'b1;
    b_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      rng = next_rand(rng);
      mem_stall = rng[0] & rng[1];
      r_ready_i = (rng[3:2] != 2'b00);
      b_ready_i = (rng[5:4] != 2'b00);
    end
  end

  // R beats are checked in read issue order.
  initial begin : r_collect
    rbeat_t e;
    forever begin
      @(posedge clk_i);
      if (r_valid_o && r_ready_i) begin
        assert (rexp_q.size() != 0) else begin
          $display("R beat with id %h arrived when none was expected", r_id_o);
          err_cnt++;
        end
        if (rexp_q.size() != 0) begin
          e = rexp_q.pop_front();
          compare_field("r_id_o", r_id_o, e.id);
          compare_field("r_resp_o", r_resp_o, e.resp);
          compare_field("r_last_o", r_last_o, e.last);
          if (e.check_data) begin
            compare_field("r_data_o", r_data_o, e.data);
          end
        end
      end
    end
  end

  // One B per write burst, in write issue order.
  initial begin : b_collect
    bexp_t e;
    forever begin
      @(posedge clk_i);
      if (b_valid_o && b_ready_i) begin
        assert (bexp_q.size() != 0) else begin
          $display("B response with id %h arrived when none was expected", b_id_o);
          err_cnt++;
        end
        if (bexp_q.size() != 0) begin
          e = bexp_q.pop_front();
          compare_field("b_id_o", b_id_o, e.id);
          compare_field("b_resp_o", b_resp_o, e.resp);
        end
      end
    end
  end

  // Entered and left on a falling edge.
  task automatic issue_read(input txn_t t);
    rbeat_t e;
    addr_t  a;
    int     cycles;
    for (int b = 0; b <= int'(t.len); b++) begin
      a = t.addr + addr_t'(4 * b);
      e.id = t.id;
      e.last = (b == int'(t.len));
      // Beats in the error region carry the row's response and no data check.
      e.check_data = (a < ErrBase);
      e.resp = e.check_data ? RESP_OKAY : t.resp;
      e.data = shadow.exists(int'(a >> 2)) ? shadow[int'(a >> 2)] : '0;
      rexp_q.push_back(e);
    end
    ar_valid_i = 1'b1;
    ar_addr_i  = t.addr;
    ar_id_i    = t.id;
    ar_len_i   = t.len;
    cycles = 0;
    @(posedge clk_i);
    while (!ar_ready_o) begin
      cycles++;
      if (cycles > Timeout) begin
        abort_on_timeout("the AR handshake");
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  task automatic issue_write(input txn_t t);
    bexp_t e;
    addr_t a;
    data_t d;
    int    cycles;
    e.id = t.id;
    e.resp = t.resp;
    bexp_q.push_back(e);
    aw_valid_i = 1'b1;
    aw_addr_i  = t.addr;
    aw_id_i    = t.id;
    aw_len_i   = t.len;
    for (int b = 0; b <= int'(t.len); b++) begin
      a = t.addr + addr_t'(4 * b);
      d = next_rand(t.seed + data_t'(b));
      w_valid_i = 1'b1;
      w_data_i  = d;
      w_strb_i  = t.strb;
      w_last_i  = (b == int'(t.len));
      cycles = 0;
      @(posedge clk_i);
      while (!w_ready_o) begin
        cycles++;
        if (cycles > Timeout) begin
          abort_on_timeout("a W handshake");
        end
        @(posedge clk_i);
      end
      // AW is taken together with the first W beat.
      if (b == 0) begin
        compare_field("aw_ready_o", aw_ready_o, 1'b1);
      end
      if (a < ErrBase) begin
        shadow[int'(a >> 2)] = apply_strobe(
          shadow.exists(int'(a >> 2)) ? shadow[int'(a >> 2)] : '0, d, t.strb);
      end
      @(negedge clk_i);
      aw_valid_i = 1'b0;
      w_valid_i  = 1'b0;
    end
  endtask

  // Drain all expected R and B traffic.
  task automatic wait_idle(input int test);
    int cycles;
    cycles = 0;
    while (rexp_q.size() != 0 || bexp_q.size() != 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) begin
        abort_on_timeout($sformatf("the responses of test %0d", test));
      end
    end
  endtask

  // Columns: test, write, addr, id, len, data seed, strobe, expected response.
  task automatic load_table();
    tbl[0]  = '{4'd1, 1'b1, 16'h0100, 4'h3, 8'd0, 32'h1111_0001, 4'hF, RESP_OKAY};
    tbl[1]  = '{4'd1, 1'b0, 16'h0100, 4'h5, 8'd0, 32'h0,         4'h0, RESP_OKAY};
    tbl[2]  = '{4'd2, 1'b1, 16'h0200, 4'h6, 8'd3, 32'h2222_0002, 4'hF, RESP_OKAY};
    tbl[3]  = '{4'd2, 1'b0, 16'h0200, 4'h7, 8'd3, 32'h0,         4'h0, RESP_OKAY};
    tbl[4]  = '{4'd3, 1'b1, 16'h0204, 4'h1, 8'd0, 32'h3333_0003, 4'h5, RESP_OKAY};
    tbl[5]  = '{4'd3, 1'b0, 16'h0200, 4'h2, 8'd1, 32'h0,         4'h0, RESP_OKAY};
    // Bursts across the start of the error region.
    tbl[6]  = '{4'd4, 1'b1, 16'hEFF8, 4'h8, 8'd3, 32'h4444_0004, 4'hF, RESP_SLVERR};
    tbl[7]  = '{4'd4, 1'b0, 16'hEFF8, 4'h9, 8'd3, 32'h0,         4'h0, RESP_SLVERR};
    // Back-to-back mix, no read overlaps a later write.
    tbl[8]  = '{4'd5, 1'b1, 16'h0300, 4'hA, 8'd3, 32'h5555_0005, 4'hF, RESP_OKAY};
    tbl[9]  = '{4'd5, 1'b0, 16'h0200, 4'hB, 8'd3, 32'h0,         4'h0, RESP_OKAY};
    tbl[10] = '{4'd5, 1'b1, 16'h0400, 4'hC, 8'd1, 32'h6666_0006, 4'hF, RESP_OKAY};
    tbl[11] = '{4'd5, 1'b0, 16'h0300, 4'hD, 8'd3, 32'h0,         4'h0, RESP_OKAY};
    tbl[12] = '{4'd5, 1'b1, 16'h0310, 4'hE, 8'd0, 32'h7777_0007, 4'hC, RESP_OKAY};
    tbl[13] = '{4'd5, 1'b0, 16'h0100, 4'h4, 8'd0, 32'h0,         4'h0, RESP_OKAY};
    tbl[14] = '{4'd5, 1'b0, 16'h0400, 4'h1, 8'd1, 32'h0,         4'h0, RESP_OKAY};
    tbl[15] = '{4'd5, 1'b1, 16'hF100, 4'h2, 8'd1, 32'h8888_0008, 4'hF, RESP_SLVERR};
  endtask

  initial begin : main
    int err_start;
    rst_i      = 1'b1;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_id_i    = '0;
    ar_len_i   = '0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_id_i    = '0;
    aw_len_i   = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    err_start  = 0;
    load_table();
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    // Nothing is requested or answered straight after reset.
    compare_field("{mem_req_o, r_valid_o, b_valid_o, ar_ready_o, aw_ready_o, w_ready_o}",
                  {mem_req_o, r_valid_o, b_valid_o, ar_ready_o, aw_ready_o, w_ready_o}, '0);
    for (int i = 0; i < NumTxn; i++) begin
      if (i == 0 || tbl[i].test != tbl[i-1].test) begin
        err_start = err_cnt;
      end
      if (tbl[i].write) begin
        issue_write(tbl[i]);
      end else begin
        issue_read(tbl[i]);
      end
      // A test ends at its last row, once all responses are in.
      if (i == NumTxn - 1 || tbl[i+1].test != tbl[i].test) begin
        wait_idle(tbl[i].test);
        tests_run++;
        if (err_cnt != err_start) begin
          tests_failed++;
        end
        $display("Test %0d: %s (%0d errors)", tbl[i].test,
                 (err_cnt == err_start) ? "passed" : "FAILED", err_cnt - err_start);
      end
    end
    finish_run();
  end

endmodule

`default_nettype wire
